//--- hw/cpu_pkg.sv
package cpu_pkg;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // ALU forms where funct7 tells SUB apart
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;

    // System forms
    localparam logic [2:0] f3_ecall = 3'b000;
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_mcycle   = 12'hb00;
    localparam logic [11:0] csr_minstret = 12'hb02;

    // RV32 with the I extension only
    localparam logic [31:0] misa_value = 32'h4000_0100;

    typedef enum logic [2:0] {
        fetch,
        fetch_wait,
        execute,
        mem_wait_st,
        halt
    } core_state_t;

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;

    // AXI response codes
    localparam logic [1:0] resp_okay = 2'b00;

endpackage

//--- hw/mem_if.sv
`timescale 1ns/1ps

interface mem_if;

    logic                        rden;
    logic [bus_pkg::addr_w-1:0] raddr;
    logic                        wren;
    logic [bus_pkg::addr_w-1:0] waddr;
    logic [bus_pkg::data_w-1:0] wdata;
    logic                        rvalid;
    logic [bus_pkg::data_w-1:0] rdata;
    logic                        busy;

    modport core (
        output rden, raddr, wren, waddr, wdata,
        input  rvalid, rdata, busy
    );

    modport bridge (
        input  rden, raddr, wren, waddr, wdata,
        output rvalid, rdata, busy
    );

endinterface

//--- hw/csr_if.sv
`timescale 1ns/1ps

interface csr_if;

    logic        rden;
    logic [11:0] raddr;
    logic        wren;
    logic [11:0] waddr;
    logic [31:0] wdata;
    logic        retire;
    logic        rvalid;
    logic [31:0] rdata;

    modport core (
        output rden, raddr, wren, waddr, wdata, retire,
        input  rvalid, rdata
    );

    modport csrs (
        input  rden, raddr, wren, waddr, wdata, retire,
        output rvalid, rdata
    );

endinterface

//--- hw/core.sv
`timescale 1ns/1ps

module core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic clk,
    input  logic rst_n,
    mem_if.core  inst_bus,
    mem_if.core  data_bus,
    csr_if.core  csr,
    output logic halted
);

    cpu_pkg::core_state_t state;

    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] regs [0:31];

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic [31:0] next_pc;
    logic        is_load;
    logic        is_store;
    logic        is_csr;
    logic        is_ecall;
    logic        take_branch;
    logic        mem_done;
    logic        wb_en;
    logic [31:0] wb_data;

    // Decode fields
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};

    assign is_load  = (opcode == cpu_pkg::op_load) && (funct3 == cpu_pkg::f3_word);
    assign is_store = (opcode == cpu_pkg::op_store) && (funct3 == cpu_pkg::f3_word);
    assign is_csr   = (opcode == cpu_pkg::op_system)
                      && ((funct3 == cpu_pkg::f3_csrrw) || (funct3 == cpu_pkg::f3_csrrs));
    assign is_ecall = (opcode == cpu_pkg::op_system) && (funct3 == cpu_pkg::f3_ecall)
                      && (instr[31:20] == 12'h000);

    // x0 reads as zero
    assign rs1_val = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

    always_comb begin
        alu_b = (opcode == cpu_pkg::op_op) ? rs2_val : imm_i;
        case (funct3)
            cpu_pkg::f3_add_sub: begin
                if ((opcode == cpu_pkg::op_op) && funct7[5]) begin
                    alu_out = rs1_val - alu_b;
                end else begin
                    alu_out = rs1_val + alu_b;
                end
            end
            cpu_pkg::f3_xor: alu_out = rs1_val ^ alu_b;
            cpu_pkg::f3_or:  alu_out = rs1_val | alu_b;
            cpu_pkg::f3_and: alu_out = rs1_val & alu_b;
            default:         alu_out = rs1_val + alu_b;
        endcase
    end

    always_comb begin
        take_branch = 1'b0;
        if (opcode == cpu_pkg::op_branch) begin
            if (funct3 == cpu_pkg::f3_beq) begin
                take_branch = (rs1_val == rs2_val);
            end else if (funct3 == cpu_pkg::f3_bne) begin
                take_branch = (rs1_val != rs2_val);
            end
        end
    end

    always_comb begin
        if (opcode == cpu_pkg::op_jal) begin
            next_pc = pc + imm_j;
        end else if (take_branch) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // Second cycle of a load or CSR access
    assign mem_done = is_csr ? csr.rvalid : data_bus.rvalid;

    always_comb begin
        wb_en   = 1'b0;
        wb_data = alu_out;
        if (state == cpu_pkg::execute) begin
            case (opcode)
                cpu_pkg::op_lui: begin
                    wb_en   = 1'b1;
                    wb_data = imm_u;
                end
                cpu_pkg::op_opimm, cpu_pkg::op_op: begin
                    wb_en = 1'b1;
                end
                cpu_pkg::op_jal: begin
                    wb_en   = 1'b1;
                    wb_data = pc + 32'd4;
                end
                default: wb_en = 1'b0;
            endcase
        end else if (state == cpu_pkg::mem_wait_st) begin
            wb_en   = mem_done;
            wb_data = is_csr ? csr.rdata : data_bus.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && (rd != 5'd0)) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == cpu_pkg::fetch_wait) && inst_bus.rvalid) begin
            instr <= inst_bus.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= cpu_pkg::fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                cpu_pkg::fetch: begin
                    // Wait out a store still in flight
                    if (!inst_bus.busy) begin
                        state <= cpu_pkg::fetch_wait;
                    end
                end
                cpu_pkg::fetch_wait: begin
                    if (inst_bus.rvalid) begin
                        state <= cpu_pkg::execute;
                    end
                end
                cpu_pkg::execute: begin
                    pc <= next_pc;
                    if (is_ecall) begin
                        state <= cpu_pkg::halt;
                    end else if (is_load || is_csr) begin
                        state <= cpu_pkg::mem_wait_st;
                    end else begin
                        state <= cpu_pkg::fetch;
                    end
                end
                cpu_pkg::mem_wait_st: begin
                    if (mem_done) begin
                        state <= cpu_pkg::fetch;
                    end
                end
                default: state <= cpu_pkg::halt;
            endcase
        end
    end

    assign inst_bus.rden  = (state == cpu_pkg::fetch) && !inst_bus.busy;
    assign inst_bus.raddr = pc;
    assign inst_bus.wren  = 1'b0;
    assign inst_bus.waddr = pc;
    assign inst_bus.wdata = '0;

    assign data_bus.rden  = (state == cpu_pkg::execute) && is_load;
    assign data_bus.raddr = rs1_val + imm_i;
    assign data_bus.wren  = (state == cpu_pkg::execute) && is_store;
    assign data_bus.waddr = rs1_val + imm_s;
    assign data_bus.wdata = rs2_val;

    // CSRRS with rs1 = x0 is a pure read
    assign csr.rden  = (state == cpu_pkg::execute) && is_csr;
    assign csr.raddr = instr[31:20];
    assign csr.wren  = (state == cpu_pkg::mem_wait_st) && is_csr && csr.rvalid
                       && ((funct3 == cpu_pkg::f3_csrrw) || (rs1 != 5'd0));
    assign csr.waddr = instr[31:20];
    assign csr.wdata = (funct3 == cpu_pkg::f3_csrrs) ? (csr.rdata | rs1_val) : rs1_val;

    assign csr.retire = ((state == cpu_pkg::execute) && !is_load && !is_csr)
                        || ((state == cpu_pkg::mem_wait_st) && mem_done);

    assign halted = (state == cpu_pkg::halt);

endmodule

//--- hw/csrs.sv
`timescale 1ns/1ps

module csrs (
    input  logic clk,
    input  logic rst_n,
    csr_if.csrs  csr
);

    logic [31:0] mscratch;
    logic [31:0] mcycle;
    logic [31:0] minstret;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mscratch <= 32'h0;
            mcycle   <= 32'h0;
            minstret <= 32'h0;
        end else begin
            mcycle <= mcycle + 32'd1;
            if (csr.retire) begin
                minstret <= minstret + 32'd1;
            end
            // Only mscratch is writable
            if (csr.wren && (csr.waddr == cpu_pkg::csr_mscratch)) begin
                mscratch <= csr.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr.rvalid <= 1'b0;
        end else begin
            csr.rvalid <= csr.rden;
        end
    end

    always_ff @(posedge clk) begin
        case (csr.raddr)
            cpu_pkg::csr_mscratch: csr.rdata <= mscratch;
            cpu_pkg::csr_mcycle:   csr.rdata <= mcycle;
            cpu_pkg::csr_minstret: csr.rdata <= minstret;
            cpu_pkg::csr_misa:     csr.rdata <= cpu_pkg::misa_value;
            default:               csr.rdata <= 32'h0;
        endcase
    end

endmodule

//--- hw/mem_axi_bridge.sv
`timescale 1ns/1ps

module mem_axi_bridge (
    input  logic                          clk,
    input  logic                          rst_n,
    mem_if.bridge                         inst_bus,
    mem_if.bridge                         data_bus,
    output logic                          bus_error,
    output logic [bus_pkg::addr_w-1:0]   awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [bus_pkg::data_w-1:0]   wdata,
    output logic [bus_pkg::data_w/8-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic [bus_pkg::addr_w-1:0]   araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [bus_pkg::data_w-1:0]   rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready
);

    logic                        pending;
    logic                        pend_write;
    logic                        pend_data;
    logic [bus_pkg::addr_w-1:0] pend_addr;
    logic [bus_pkg::data_w-1:0] pend_wdata;
    logic [bus_pkg::data_w-1:0] rsp_data;
    logic                        aw_pend;
    logic                        w_pend;
    logic                        ar_pend;
    logic                        inst_rvalid_q;
    logic                        data_rvalid_q;
    logic                        use_data;
    logic                        req;
    logic                        req_write;
    logic [bus_pkg::addr_w-1:0] req_addr;
    logic [bus_pkg::data_w-1:0] req_wdata;

    // Data port wins a same-cycle tie
    assign use_data = data_bus.rden | data_bus.wren;
    assign req      = use_data | inst_bus.rden | inst_bus.wren;

    always_comb begin
        if (use_data) begin
            req_write = data_bus.wren;
            req_addr  = data_bus.wren ? data_bus.waddr : data_bus.raddr;
            req_wdata = data_bus.wdata;
        end else begin
            req_write = inst_bus.wren;
            req_addr  = inst_bus.wren ? inst_bus.waddr : inst_bus.raddr;
            req_wdata = inst_bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            pend_write <= req_write;
            pend_data  <= use_data;
            pend_addr  <= req_addr;
            pend_wdata <= req_wdata;
        end
        if (rvalid && rready) begin
            rsp_data <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending       <= 1'b0;
            aw_pend       <= 1'b0;
            w_pend        <= 1'b0;
            ar_pend       <= 1'b0;
            inst_rvalid_q <= 1'b0;
            data_rvalid_q <= 1'b0;
            bus_error     <= 1'b0;
        end else begin
            inst_rvalid_q <= 1'b0;
            data_rvalid_q <= 1'b0;
            if (req) begin
                pending <= 1'b1;
                aw_pend <= req_write;
                w_pend  <= req_write;
                ar_pend <= !req_write;
            end else begin
                if (awvalid && awready) begin
                    aw_pend <= 1'b0;
                end
                if (wvalid && wready) begin
                    w_pend <= 1'b0;
                end
                if (arvalid && arready) begin
                    ar_pend <= 1'b0;
                end
                if (bvalid && bready) begin
                    pending <= 1'b0;
                    if (bresp != bus_pkg::resp_okay) begin
                        bus_error <= 1'b1;
                    end
                end
                if (rvalid && rready) begin
                    pending       <= 1'b0;
                    inst_rvalid_q <= !pend_data;
                    data_rvalid_q <= pend_data;
                    if (rresp != bus_pkg::resp_okay) begin
                        bus_error <= 1'b1;
                    end
                end
            end
        end
    end

    assign awaddr  = pend_addr;
    assign awvalid = aw_pend;
    assign wdata   = pend_wdata;
    assign wstrb   = '1;
    assign wvalid  = w_pend;
    assign bready  = pending && pend_write;
    assign araddr  = pend_addr;
    assign arvalid = ar_pend;
    assign rready  = pending && !pend_write;

    assign inst_bus.rvalid = inst_rvalid_q;
    assign inst_bus.rdata  = rsp_data;
    assign inst_bus.busy   = pending;
    assign data_bus.rvalid = data_rvalid_q;
    assign data_bus.rdata  = rsp_data;
    assign data_bus.busy   = pending;

endmodule

//--- hw/rv_soc.sv
`timescale 1ns/1ps

module rv_soc #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          halted,
    output logic                          bus_error,
    output logic [bus_pkg::addr_w-1:0]   awaddr,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [bus_pkg::data_w-1:0]   wdata,
    output logic [bus_pkg::data_w/8-1:0] wstrb,
    output logic                          wvalid,
    input  logic                          wready,
    input  logic [1:0]                    bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic [bus_pkg::addr_w-1:0]   araddr,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [bus_pkg::data_w-1:0]   rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready
);

    mem_if inst_bus ();
    mem_if data_bus ();
    csr_if csr_bus ();

    core #(
        .reset_pc (reset_pc)
    ) u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_bus (inst_bus.core),
        .data_bus (data_bus.core),
        .csr      (csr_bus.core),
        .halted   (halted)
    );

    csrs u_csrs (
        .clk   (clk),
        .rst_n (rst_n),
        .csr   (csr_bus.csrs)
    );

    // Single AXI master shared by fetch and data
    mem_axi_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_bus  (inst_bus.bridge),
        .data_bus  (data_bus.bridge),
        .bus_error (bus_error),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

endmodule

//--- dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        run_b,
    input logic        halted,
    input logic        bus_error,
    input logic [31:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb,
    input logic        wvalid,
    input logic        wready,
    input logic        bvalid,
    input logic        bready,
    input logic        arvalid,
    input logic [31:0] pat [0:255]
);

    integer      idx;
    integer      pass_cnt = 0;
    integer      fail_cnt = 0;
    integer      err_cnt = 0;
    logic        test_bad;
    logic        late_seen;
    logic        berr_seen;
    logic [31:0] cur_addr;
    logic [31:0] cur_data;

    task check_store();
        integer base;
        base = 194 + 3 * idx;
        if (idx >= pat[193]) begin
            $display("run %s: unexpected extra store to %h", run_b ? "B" : "A", cur_addr);
            err_cnt = err_cnt + 1;
        end else begin
            if ((cur_addr !== pat[base]) || (cur_data !== pat[base + 1])) begin
                $display("ERR %0t: store %0d addr %h expected %h, observed addr %h data %h",
                         $time, idx, pat[base], pat[base + 1], cur_addr, cur_data);
                err_cnt = err_cnt + 1;
                test_bad = 1'b1;
            end
            // Last store of a test closes it
            if ((idx + 1 == pat[193]) || (pat[base + 5] != pat[base + 2])) begin
                if (test_bad) begin
                    fail_cnt = fail_cnt + 1;
                end else begin
                    pass_cnt = pass_cnt + 1;
                end
                $display("run %s test %0d: %s", run_b ? "B" : "A", pat[base + 2],
                         test_bad ? "fail" : "pass");
                test_bad = 1'b0;
            end
        end
        idx = idx + 1;
    endtask

    task finish_run();
        if (idx != pat[193]) begin
            $display("run %s: only %0d of %0d stores were seen", run_b ? "B" : "A",
                     idx, pat[193]);
            err_cnt = err_cnt + 1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            idx       = 0;
            test_bad  = 1'b0;
            late_seen = 1'b0;
            berr_seen = 1'b0;
        end else begin
            if (awvalid && awready) begin
                cur_addr = awaddr;
            end
            if (wvalid && wready) begin
                cur_data = wdata;
                // Word stores only, so every byte lane is enabled
                if (wstrb !== 4'hf) begin
                    $display("ERR %0t: wstrb expected f, observed %h", $time, wstrb);
                    err_cnt  = err_cnt + 1;
                    test_bad = 1'b1;
                end
            end
            if (bvalid && bready) begin
                check_store();
            end
            // Nothing may reach the bus once the core has halted
            if (halted && (arvalid || awvalid) && !late_seen) begin
                $display("run %s: AXI request issued after halt", run_b ? "B" : "A");
                err_cnt   = err_cnt + 1;
                late_seen = 1'b1;
            end
            if (bus_error && !berr_seen) begin
                $display("run %s: bus_error went high", run_b ? "B" : "A");
                err_cnt   = err_cnt + 1;
                berr_seen = 1'b1;
            end
        end
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    logic        clk;
    logic        rst_n;
    logic        halted;
    logic        bus_error;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] pat [0:255];
    logic [31:0] mem [0:255];
    integer      seed;
    integer      nprog;
    logic        run_b;

    // Memory model state
    logic [31:0] r_addr;
    logic [31:0] w_addr;
    logic [31:0] w_data;
    logic        aw_got;
    logic        w_got;
    logic        r_pend;
    logic        b_pend;
    integer      r_cnt;
    integer      b_cnt;
    integer      ar_gap;
    integer      aw_gap;
    integer      w_gap;

    rv_soc #(
        .reset_pc (32'h0000_0000)
    ) u_rv_soc (
        .clk (clk), .rst_n (rst_n), .halted (halted), .bus_error (bus_error),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
    );

    tb_checker u_checker (
        .clk (clk), .rst_n (rst_n), .run_b (run_b), .halted (halted),
        .bus_error (bus_error), .awaddr (awaddr), .awvalid (awvalid),
        .awready (awready), .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid),
        .wready (wready), .bvalid (bvalid), .bready (bready), .arvalid (arvalid),
        .pat (pat)
    );

    // Zero in run A, 0 to 5 cycles in run B
    function integer pick_delay();
        if (run_b) begin
            pick_delay = $unsigned($random(seed)) % 6;
        end else begin
            pick_delay = 0;
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : responder
        logic        hs_ar;
        logic        hs_r;
        logic        hs_aw;
        logic        hs_w;
        logic        hs_b;
        logic        v_ar;
        logic        v_aw;
        logic        v_w;
        logic [31:0] ar_a;
        logic [31:0] aw_a;
        logic [31:0] w_d;
        forever begin
            @(posedge clk);
            hs_ar = arvalid && arready;
            hs_r  = rvalid && rready;
            hs_aw = awvalid && awready;
            hs_w  = wvalid && wready;
            hs_b  = bvalid && bready;
            v_ar  = arvalid;
            v_aw  = awvalid;
            v_w   = wvalid;
            ar_a  = araddr;
            aw_a  = awaddr;
            w_d   = wdata;
            #1;
            if (!rst_n) begin
                aw_got = 1'b0;
                w_got  = 1'b0;
                r_pend = 1'b0;
                b_pend = 1'b0;
                ar_gap = 0;
                aw_gap = 0;
                w_gap  = 0;
                rvalid = 1'b0;
                bvalid = 1'b0;
            end else begin
                if (hs_ar) begin
                    r_addr = ar_a;
                    r_pend = 1'b1;
                    r_cnt  = pick_delay();
                    ar_gap = pick_delay();
                end
                if (hs_r) begin
                    rvalid = 1'b0;
                    r_pend = 1'b0;
                end
                if (hs_aw) begin
                    w_addr = aw_a;
                    aw_got = 1'b1;
                    aw_gap = pick_delay();
                end
                if (hs_w) begin
                    w_data = w_d;
                    w_got  = 1'b1;
                    w_gap  = pick_delay();
                end
                if (aw_got && w_got) begin
                    mem[w_addr[9:2]] = w_data;
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_pend = 1'b1;
                    b_cnt  = pick_delay();
                end
                if (hs_b) begin
                    bvalid = 1'b0;
                    b_pend = 1'b0;
                end
                if (r_pend && !rvalid) begin
                    if (r_cnt == 0) begin
                        rvalid = 1'b1;
                        rdata  = mem[r_addr[9:2]];
                    end else begin
                        r_cnt = r_cnt - 1;
                    end
                end
                if (b_pend && !bvalid) begin
                    if (b_cnt == 0) begin
                        bvalid = 1'b1;
                    end else begin
                        b_cnt = b_cnt - 1;
                    end
                end
                // Ready gaps count down only while the next valid waits
                if (v_ar && !hs_ar && (ar_gap > 0)) begin
                    ar_gap = ar_gap - 1;
                end
                if (v_aw && !hs_aw && (aw_gap > 0)) begin
                    aw_gap = aw_gap - 1;
                end
                if (v_w && !hs_w && (w_gap > 0)) begin
                    w_gap = w_gap - 1;
                end
            end
            arready = (ar_gap == 0) && !r_pend;
            awready = (aw_gap == 0) && !aw_got && !b_pend;
            wready  = (w_gap == 0) && !w_got && !b_pend;
        end
    end

    task run_program(input logic with_delays);
        integer i;
        @(posedge clk);
        #1;
        run_b = with_delays;
        rst_n = 1'b0;
        for (i = 0; i < 256; i = i + 1) begin
            mem[i] = pat[i];
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (halted === 1'b1);
        // Quiet period to catch stray bus traffic after halt
        repeat (20) @(posedge clk);
        u_checker.finish_run();
    endtask

    initial begin : watchdog
        wait (nprog > 0);
        #(nprog * 8000.0);
        $display("Timeout: run %s never reached halt", run_b ? "B" : "A");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bresp   = 2'b00;
        bvalid  = 1'b0;
        arready = 1'b0;
        rdata   = 32'h0;
        rresp   = 2'b00;
        rvalid  = 1'b0;
        run_b   = 1'b0;
        nprog   = 0;
        seed    = 32'h3100731d;
        $readmemh("dv/soc_patterns.txt", pat);
        nprog = pat[192];
        run_program(1'b0);
        run_program(1'b1);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 u_checker.pass_cnt, u_checker.fail_cnt, u_checker.err_cnt);
        if ((u_checker.fail_cnt == 0) && (u_checker.err_cnt == 0)
            && (u_checker.pass_cnt == 8)) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- dv/soc_patterns.txt
// Word image for the memory model, one 32-bit hex word per entry, @ gives a word index
// Program at word 0, load data at word 0x3c
// Word 0xc0 holds the program word count, 0xc1 the store count
// From 0xc2 each line holds one expected store: address, data, test number
@0
10000113 00500093 00112023 00c00193 // base, x1 = 5, x3 = 12
00308233 00412223 401182b3 00512423 // add, sub
0030f333 00612623 0030e3b3 00712823 // and, or
0030c433 00812a23 123454b7 00912c23 // xor, lui
0f002503 01050513 00a12e23 00100593 // lw + 0x10
00108463 02012023 02b12023 00308463 // beq taken, beq not taken
00158593 02b12223 00309463 02012423 // bne taken
00109463 00158593 02b12423 0080066f // bne not taken, jal
02012623 02c12623 05a00693 34069773 // csrrw to mscratch
340017f3 02f12823 02e12a23 30102873 // read back, misa
03012c23 b02028f3 03112e23 00000073 // minstret, ecall
@3c
11223344
@c0
0000002c 00000010
00000100 00000005 00000001
00000104 00000011 00000001
00000108 00000007 00000001
0000010c 00000004 00000001
00000110 0000000d 00000001
00000114 00000009 00000001
00000118 12345000 00000001
0000011c 11223354 00000002
00000120 00000001 00000003
00000124 00000002 00000003
00000128 00000003 00000003
0000012c 00000080 00000003
00000130 0000005a 00000004
00000134 00000000 00000004
00000138 40000100 00000004
0000013c 00000026 00000004

//--- filelist.f
hw/cpu_pkg.sv
hw/bus_pkg.sv
hw/mem_if.sv
hw/csr_if.sv
hw/core.sv
hw/csrs.sv
hw/mem_axi_bridge.sv
hw/rv_soc.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLAGS     ?= --binary --timing

SRCS := $(shell grep -v '^+' filelist.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) filelist.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f filelist.f

# Output goes to the terminal, grep decides the exit status
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
